// File: common/csi2_vpg_pkg.sv
package csi2_vpg_pkg;

	localparam int PLD_WIDTH = 64;	// Payload beat, 8 bytes
	localparam int WC_WIDTH  = 16;	// Word count field
	localparam int VC_WIDTH  = 2;	// VC and VCX fields

	// CSI-2 data type codes
	typedef enum logic [5:0] {
		dt_fs     = 6'h00,	// Frame start
		dt_fe     = 6'h01,	// Frame end
		dt_ls     = 6'h02,	// Line start
		dt_le     = 6'h03,	// Line end
		dt_rgb888 = 6'h24,
		dt_raw8   = 6'h2a
	} vpg_dt_e;

	// Packet request kinds from the timing engine
	typedef enum logic [2:0] {
		req_fs,
		req_fe,
		req_ls,
		req_le,
		req_long
	} vpg_req_e;

	typedef enum logic {
		pat_ramp,	// Byte value steps by one
		pat_solid	// Whole line one value
	} vpg_pattern_e;

	// Short packets carry no payload, DT[5:2] is zero for them
	function automatic logic is_short_dt(input logic [5:0] dt);
		return (dt[5:2] == 4'd0);
	endfunction

endpackage

// File: vpg/vpg_frame_timing.sv
`timescale 1ns/100ps

// Frame layout is vsa, vbp, active, vfp. vsa, active and vfp need at least one line,
// vbp may be empty
module vpg_frame_timing #(
	parameter int LINE_W = 10,
	parameter int TIME_W = 12
) (
	input  logic                   ppi_clk,
	input  logic                   ppi_clkrstz,
	input  logic                   vpg_en,
	input  logic [LINE_W-1:0]      vpg_vsa_lines,
	input  logic [LINE_W-1:0]      vpg_vbp_lines,
	input  logic [LINE_W-1:0]      vpg_vactive_lines,
	input  logic [LINE_W-1:0]      vpg_vfp_lines,
	input  logic [TIME_W-1:0]      vpg_hsa_time,
	input  logic [TIME_W-1:0]      vpg_hbp_time,
	input  logic [TIME_W-1:0]      vpg_hline_time,
	input  logic                   vpg_hsync_packet_en,
	output logic                   req,
	output csi2_vpg_pkg::vpg_req_e req_kind,
	output logic [LINE_W-1:0]      line_idx,
	output logic                   frame_done
);
	import csi2_vpg_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_vsa,
		st_vbp,
		st_active,
		st_vfp
	} state_e;

	state_e            state;
	state_e            next_region;
	logic [TIME_W-1:0] cyc_cnt;
	logic [LINE_W-1:0] line_cnt;
	logic [LINE_W-1:0] region_lines;
	logic              line_last_cyc;
	logic              region_last_line;
	logic [TIME_W:0]   long_pos;

	always_comb begin
		case (state)
			st_vsa:    region_lines = vpg_vsa_lines;
			st_vbp:    region_lines = vpg_vbp_lines;
			st_active: region_lines = vpg_vactive_lines;
			st_vfp:    region_lines = vpg_vfp_lines;
			default:   region_lines = '0;
		endcase
	end

	always_comb begin
		case (state)
			st_vsa:    next_region = (vpg_vbp_lines != '0) ? st_vbp : st_active;	// Skip empty vbp
			st_vbp:    next_region = st_active;
			st_active: next_region = st_vfp;
			default:   next_region = vpg_en ? st_vsa : st_idle;	// Stop after frame when disabled
		endcase
	end

	assign line_last_cyc    = (cyc_cnt == vpg_hline_time - 1'b1);
	assign region_last_line = (line_cnt == region_lines - 1'b1);
	assign long_pos         = {1'b0, vpg_hsa_time} + {1'b0, vpg_hbp_time};	// Long packet slot

	always_ff @(posedge ppi_clk or negedge ppi_clkrstz) begin
		if (!ppi_clkrstz) begin
			state    <= st_idle;
			cyc_cnt  <= '0;
			line_cnt <= '0;
		end else if (state == st_idle) begin
			cyc_cnt  <= '0;
			line_cnt <= '0;
			if (vpg_en)
				state <= st_vsa;
		end else if (line_last_cyc) begin
			cyc_cnt <= '0;
			if (region_last_line) begin
				line_cnt <= '0;
				state    <= next_region;
			end else begin
				line_cnt <= line_cnt + 1'b1;
			end
		end else begin
			cyc_cnt <= cyc_cnt + 1'b1;
		end
	end

	// Request decode from the line position
	always_comb begin
		req      = 1'b0;
		req_kind = req_long;
		if (state == st_vsa && line_cnt == '0 && cyc_cnt == '0) begin
			req      = 1'b1;
			req_kind = req_fs;
		end else if (state == st_vfp && line_cnt == '0 && cyc_cnt == '0) begin
			req      = 1'b1;
			req_kind = req_fe;
		end else if (state == st_active) begin
			if (vpg_hsync_packet_en && cyc_cnt == '0) begin
				req      = 1'b1;
				req_kind = req_ls;
			end else if ({1'b0, cyc_cnt} == long_pos) begin
				req      = 1'b1;
				req_kind = req_long;
			end else if (vpg_hsync_packet_en && line_last_cyc) begin
				req      = 1'b1;
				req_kind = req_le;
			end
		end
	end

	assign line_idx   = (state == st_active) ? line_cnt : '0;
	assign frame_done = (state == st_vfp) && region_last_line && line_last_cyc;	// Last vfp cycle

endmodule

// File: vpg/vpg_packet_builder.sv
`timescale 1ns/100ps

module vpg_packet_builder #(
	parameter int LINE_W = 10
) (
	input  logic                                  ppi_clk,
	input  logic                                  ppi_clkrstz,
	input  logic                                  req,
	input  csi2_vpg_pkg::vpg_req_e                req_kind,
	input  logic [LINE_W-1:0]                     line_idx,
	input  logic                                  frame_done,
	input  logic                                  payload_pop,
	input  logic [csi2_vpg_pkg::WC_WIDTH-1:0]     vpg_pkt_size,
	input  csi2_vpg_pkg::vpg_dt_e                 vpg_dt,
	input  logic [csi2_vpg_pkg::VC_WIDTH-1:0]     vpg_vc,
	input  logic [csi2_vpg_pkg::VC_WIDTH-1:0]     vpg_vcx,
	input  csi2_vpg_pkg::vpg_pattern_e            vpg_pattern,
	input  logic                                  vpg_frame_num_mode,
	input  logic [csi2_vpg_pkg::WC_WIDTH-1:0]     vpg_max_frame_num,
	input  logic                                  vpg_line_num_mode,
	input  logic [csi2_vpg_pkg::WC_WIDTH-1:0]     vpg_start_line_num,
	input  logic [csi2_vpg_pkg::WC_WIDTH-1:0]     vpg_step_line_num,
	output logic                                  packet_req,
	output csi2_vpg_pkg::vpg_dt_e                 hdr_dt,
	output logic [csi2_vpg_pkg::VC_WIDTH-1:0]     hdr_vc,
	output logic [csi2_vpg_pkg::VC_WIDTH-1:0]     hdr_vcx,
	output logic [csi2_vpg_pkg::WC_WIDTH-1:0]     hdr_wc,
	output logic [csi2_vpg_pkg::PLD_WIDTH-1:0]    payload
);
	import csi2_vpg_pkg::*;

	localparam int BEAT_W = 5;	// Ramp repeats every 32 beats

	logic [WC_WIDTH-1:0] frame_cnt;
	logic [WC_WIDTH-1:0] frame_num;
	logic [WC_WIDTH-1:0] line_num;
	logic [BEAT_W-1:0]   beat_idx;
	logic [7:0]          line_byte;
	logic [7:0]          beat_base;

	assign packet_req = req;
	assign hdr_vc     = vpg_vc;
	assign hdr_vcx    = vpg_vcx;

	// Frame counter runs 1..max, advanced at the end of each frame
	always_ff @(posedge ppi_clk or negedge ppi_clkrstz) begin
		if (!ppi_clkrstz)
			frame_cnt <= WC_WIDTH'(1);
		else if (frame_done)
			frame_cnt <= (frame_cnt >= vpg_max_frame_num) ? WC_WIDTH'(1) : frame_cnt + 1'b1;
	end

	assign frame_num = vpg_frame_num_mode ? frame_cnt : '0;
	assign line_num  = vpg_line_num_mode ?
		vpg_start_line_num + vpg_step_line_num * WC_WIDTH'(line_idx) : '0;

	// Between requests the header rests on the long packet fields
	always_comb begin
		case (req_kind)
			req_fs: begin
				hdr_dt = dt_fs;
				hdr_wc = frame_num;
			end
			req_fe: begin
				hdr_dt = dt_fe;
				hdr_wc = frame_num;
			end
			req_ls: begin
				hdr_dt = dt_ls;
				hdr_wc = line_num;
			end
			req_le: begin
				hdr_dt = dt_le;
				hdr_wc = line_num;
			end
			default: begin
				hdr_dt = vpg_dt;
				hdr_wc = vpg_pkt_size;	// Byte count
			end
		endcase
	end

	always_ff @(posedge ppi_clk or negedge ppi_clkrstz) begin
		if (!ppi_clkrstz)
			beat_idx <= '0;
		else if (req && req_kind == req_long)
			beat_idx <= '0;	// Restart for new line
		else if (payload_pop)
			beat_idx <= beat_idx + 1'b1;
	end

	assign line_byte = 8'(line_idx);
	assign beat_base = line_byte + {beat_idx, 3'b000};	// line + 8i, mod 256

	always_comb begin
		for (int k = 0; k < PLD_WIDTH / 8; k++) begin
			if (vpg_pattern == pat_solid)
				payload[8*k +: 8] = line_byte;
			else
				payload[8*k +: 8] = beat_base + 8'(k);
		end
	end

endmodule

// File: logic/vpg_idi.sv
`timescale 1ns/100ps

module vpg_idi (
	input  logic                                  ppi_clk,
	input  logic                                  ppi_clkrstz,
	input  logic                                  packet_req,
	input  csi2_vpg_pkg::vpg_dt_e                 hdr_dt,
	input  logic [csi2_vpg_pkg::VC_WIDTH-1:0]     hdr_vc,
	input  logic [csi2_vpg_pkg::VC_WIDTH-1:0]     hdr_vcx,
	input  logic [csi2_vpg_pkg::WC_WIDTH-1:0]     hdr_wc,
	input  logic [csi2_vpg_pkg::PLD_WIDTH-1:0]    payload,
	output logic                                  payload_pop,
	output logic                                  idi_header_en,
	output logic                                  idi_data_en,
	output logic [csi2_vpg_pkg::PLD_WIDTH-1:0]    idi_data,
	output logic [2:0]                            idi_byte_en,
	output logic [csi2_vpg_pkg::WC_WIDTH-1:0]     idi_word_count,
	output logic [csi2_vpg_pkg::VC_WIDTH-1:0]     idi_vc,
	output logic [csi2_vpg_pkg::VC_WIDTH-1:0]     idi_vcx,
	output logic [5:0]                            idi_dt
);
	import csi2_vpg_pkg::*;

	logic                long_req;
	logic [WC_WIDTH-1:0] rem_bytes;
	logic                data_active;
	logic                full_beat;
	logic                lock_vld;
	logic [VC_WIDTH-1:0] lock_vc;
	logic [VC_WIDTH-1:0] lock_vcx;
	logic [5:0]          lock_dt;

	assign long_req    = packet_req && !is_short_dt(hdr_dt);
	assign data_active = |rem_bytes;
	assign full_beat   = |rem_bytes[WC_WIDTH-1:3];	// 8 or more bytes left

	// Bytes still to send, 8 per beat
	always_ff @(posedge ppi_clk or negedge ppi_clkrstz) begin
		if (!ppi_clkrstz)
			rem_bytes <= '0;
		else if (long_req)
			rem_bytes <= hdr_wc;
		else if (full_beat)
			rem_bytes <= rem_bytes - WC_WIDTH'(8);
		else
			rem_bytes <= '0;	// Partial beat drains the rest
	end

	assign payload_pop    = data_active;
	assign idi_data_en    = data_active;
	assign idi_header_en  = packet_req | data_active;
	assign idi_data       = data_active ? payload : '0;
	assign idi_word_count = hdr_wc;

	always_comb begin
		if (full_beat)
			idi_byte_en = 3'd7;
		else if (data_active)
			idi_byte_en = rem_bytes[2:0] - 1'b1;	// Last valid byte index
		else
			idi_byte_en = 3'd0;
	end

	// Channel fields held until the final beat
	always_ff @(posedge ppi_clk or negedge ppi_clkrstz) begin
		if (!ppi_clkrstz) begin
			lock_vld <= 1'b0;
			lock_vc  <= '0;
			lock_vcx <= '0;
			lock_dt  <= '0;
		end else if (long_req) begin
			lock_vld <= 1'b1;
			lock_vc  <= hdr_vc;
			lock_vcx <= hdr_vcx;
			lock_dt  <= hdr_dt;
		end else if (rem_bytes <= WC_WIDTH'(8)) begin
			lock_vld <= 1'b0;
		end
	end

	assign idi_vc  = packet_req ? hdr_vc : (lock_vld ? lock_vc : '0);
	assign idi_vcx = packet_req ? hdr_vcx : (lock_vld ? lock_vcx : '0);
	assign idi_dt  = packet_req ? hdr_dt : (lock_vld ? lock_dt : 6'd0);

endmodule

// File: logic/csi2_device_vpg_top.sv
`timescale 1ns/100ps

module csi2_device_vpg_top #(
	parameter int LINE_W = 10,
	parameter int TIME_W = 12
) (
	input  logic                                  ppi_clk,
	input  logic                                  ppi_clkrstz,
	input  logic                                  vpg_en,
	input  logic [LINE_W-1:0]                     vpg_vsa_lines,
	input  logic [LINE_W-1:0]                     vpg_vbp_lines,
	input  logic [LINE_W-1:0]                     vpg_vactive_lines,
	input  logic [LINE_W-1:0]                     vpg_vfp_lines,
	input  logic [TIME_W-1:0]                     vpg_hsa_time,
	input  logic [TIME_W-1:0]                     vpg_hbp_time,
	input  logic [TIME_W-1:0]                     vpg_hline_time,
	input  logic [csi2_vpg_pkg::WC_WIDTH-1:0]     vpg_pkt_size,
	input  csi2_vpg_pkg::vpg_dt_e                 vpg_dt,
	input  logic [csi2_vpg_pkg::VC_WIDTH-1:0]     vpg_vc,
	input  logic [csi2_vpg_pkg::VC_WIDTH-1:0]     vpg_vcx,
	input  csi2_vpg_pkg::vpg_pattern_e            vpg_pattern,
	input  logic                                  vpg_hsync_packet_en,
	input  logic                                  vpg_frame_num_mode,
	input  logic [csi2_vpg_pkg::WC_WIDTH-1:0]     vpg_max_frame_num,
	input  logic                                  vpg_line_num_mode,
	input  logic [csi2_vpg_pkg::WC_WIDTH-1:0]     vpg_start_line_num,
	input  logic [csi2_vpg_pkg::WC_WIDTH-1:0]     vpg_step_line_num,
	output logic                                  idi_header_en,
	output logic                                  idi_data_en,
	output logic [csi2_vpg_pkg::PLD_WIDTH-1:0]    idi_data,
	output logic [2:0]                            idi_byte_en,
	output logic [csi2_vpg_pkg::WC_WIDTH-1:0]     idi_word_count,
	output logic [csi2_vpg_pkg::VC_WIDTH-1:0]     idi_vc,
	output logic [csi2_vpg_pkg::VC_WIDTH-1:0]     idi_vcx,
	output logic [5:0]                            idi_dt
);
	import csi2_vpg_pkg::*;

	logic                 req;
	vpg_req_e             req_kind;
	logic [LINE_W-1:0]    line_idx;
	logic                 frame_done;
	logic                 payload_pop;
	logic                 packet_req;
	vpg_dt_e              hdr_dt;
	logic [VC_WIDTH-1:0]  hdr_vc;
	logic [VC_WIDTH-1:0]  hdr_vcx;
	logic [WC_WIDTH-1:0]  hdr_wc;
	logic [PLD_WIDTH-1:0] payload;

	vpg_frame_timing #(
		.LINE_W (LINE_W),
		.TIME_W (TIME_W)
	) u_frame_timing (
		.ppi_clk             (ppi_clk),
		.ppi_clkrstz         (ppi_clkrstz),
		.vpg_en              (vpg_en),
		.vpg_vsa_lines       (vpg_vsa_lines),
		.vpg_vbp_lines       (vpg_vbp_lines),
		.vpg_vactive_lines   (vpg_vactive_lines),
		.vpg_vfp_lines       (vpg_vfp_lines),
		.vpg_hsa_time        (vpg_hsa_time),
		.vpg_hbp_time        (vpg_hbp_time),
		.vpg_hline_time      (vpg_hline_time),
		.vpg_hsync_packet_en (vpg_hsync_packet_en),
		.req                 (req),
		.req_kind            (req_kind),
		.line_idx            (line_idx),
		.frame_done          (frame_done)
	);

	vpg_packet_builder #(
		.LINE_W (LINE_W)
	) u_packet_builder (
		.ppi_clk            (ppi_clk),
		.ppi_clkrstz        (ppi_clkrstz),
		.req                (req),
		.req_kind           (req_kind),
		.line_idx           (line_idx),
		.frame_done         (frame_done),
		.payload_pop        (payload_pop),
		.vpg_pkt_size       (vpg_pkt_size),
		.vpg_dt             (vpg_dt),
		.vpg_vc             (vpg_vc),
		.vpg_vcx            (vpg_vcx),
		.vpg_pattern        (vpg_pattern),
		.vpg_frame_num_mode (vpg_frame_num_mode),
		.vpg_max_frame_num  (vpg_max_frame_num),
		.vpg_line_num_mode  (vpg_line_num_mode),
		.vpg_start_line_num (vpg_start_line_num),
		.vpg_step_line_num  (vpg_step_line_num),
		.packet_req         (packet_req),
		.hdr_dt             (hdr_dt),
		.hdr_vc             (hdr_vc),
		.hdr_vcx            (hdr_vcx),
		.hdr_wc             (hdr_wc),
		.payload            (payload)
	);

	vpg_idi u_idi (
		.ppi_clk        (ppi_clk),
		.ppi_clkrstz    (ppi_clkrstz),
		.packet_req     (packet_req),
		.hdr_dt         (hdr_dt),
		.hdr_vc         (hdr_vc),
		.hdr_vcx        (hdr_vcx),
		.hdr_wc         (hdr_wc),
		.payload        (payload),
		.payload_pop    (payload_pop),
		.idi_header_en  (idi_header_en),
		.idi_data_en    (idi_data_en),
		.idi_data       (idi_data),
		.idi_byte_en    (idi_byte_en),
		.idi_word_count (idi_word_count),
		.idi_vc         (idi_vc),
		.idi_vcx        (idi_vcx),
		.idi_dt         (idi_dt)
	);

endmodule

// File: verification/tb_csi2_device_vpg.sv
`timescale 1ns/100ps

module tb_csi2_device_vpg;
	import csi2_vpg_pkg::*;

	localparam int MAX_TESTS = 16;
	localparam int NF        = 21;	// Fields per test line

	logic [15:0] cfg_mem [0:MAX_TESTS*NF-1];
	logic ppi_clk, ppi_clkrstz, vpg_en;
	logic [9:0]  vpg_vsa_lines, vpg_vbp_lines, vpg_vactive_lines, vpg_vfp_lines;
	logic [11:0] vpg_hsa_time, vpg_hbp_time, vpg_hline_time;
	logic [15:0] vpg_pkt_size, vpg_max_frame_num, vpg_start_line_num, vpg_step_line_num;
	vpg_dt_e      vpg_dt;
	logic [1:0]   vpg_vc, vpg_vcx;
	vpg_pattern_e vpg_pattern;
	logic vpg_hsync_packet_en, vpg_frame_num_mode, vpg_line_num_mode;
	logic idi_header_en, idi_data_en;
	logic [63:0] idi_data;
	logic [2:0]  idi_byte_en;
	logic [15:0] idi_word_count;
	logic [1:0]  idi_vc, idi_vcx;
	logic [5:0]  idi_dt;

	vpg_dt_e     exp_dt_q [$];
	logic [15:0] exp_wc_q [$];
	int          exp_line_q [$];
	int errors, num_tests, tests_pass, tests_fail;
	int got_short, got_long, fs_seen, fe_seen, exp_beats, beat_i, cur_line;
	longint cycles, cycle_limit;
	bit mon_on;

	csi2_device_vpg_top #(.LINE_W(10), .TIME_W(12)) DUT (.*);

	initial begin
		ppi_clk = 1'b0;
		forever #50 ppi_clk = ~ppi_clk;
	end

	// Watchdog over the whole run
	always @(posedge ppi_clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Verification failed");
			$finish;
		end
	end

	task automatic check_short(input vpg_dt_e dt, input logic [15:0] wc);
		if (idi_dt !== dt || idi_word_count !== wc) begin
			$display("MISMATCH at %0t: header dt 0x%h wc 0x%h, expected dt 0x%h wc 0x%h",
				$time, idi_dt, idi_word_count, dt, wc);
			errors++;
		end
	endtask

	task automatic check_long_beat(input logic [63:0] data, input logic [2:0] be,
		input vpg_dt_e dt);
		if (idi_data !== data || idi_byte_en !== be || idi_dt !== dt) begin
			$display("MISMATCH at %0t: beat %0d data 0x%h be %0d dt 0x%h, expected 0x%h %0d 0x%h",
				$time, beat_i, idi_data, idi_byte_en, idi_dt, data, be, dt);
			errors++;
		end
	endtask

	task automatic check_channel(input logic [1:0] vc, input logic [1:0] vcx);
		if (idi_vc !== vc || idi_vcx !== vcx) begin
			$display("MISMATCH at %0t: vc %0d vcx %0d, expected %0d %0d",
				$time, idi_vc, idi_vcx, vc, vcx);
			errors++;
		end
	endtask

	task automatic check_idle_data(input logic [63:0] data);
		if (data !== 64'd0) begin
			$display("MISMATCH at %0t: idi_data 0x%h outside a data cycle", $time, data);
			errors++;
		end
	endtask

	task automatic check_count(input int exp_s, input int exp_l, input int s, input int l);
		if (exp_s != s || exp_l != l) begin
			$display("MISMATCH at %0t: %0d short and %0d long packets, expected %0d and %0d",
				$time, s, l, exp_s, exp_l);
			errors++;
		end
	endtask

	task automatic take_header();
		vpg_dt_e     dt;
		logic [15:0] wc;
		if (beat_i != exp_beats) begin
			$display("Long packet at %0t ended after %0d beats instead of %0d",
				$time, beat_i, exp_beats);
			errors++;
		end
		exp_beats = 0;
		beat_i    = 0;
		if (idi_dt <= 6'd3)
			got_short++;
		else
			got_long++;
		if (idi_dt == 6'd0)
			fs_seen++;
		if (idi_dt == 6'd1)
			fe_seen++;
		if (exp_dt_q.size() == 0) begin
			$display("Unexpected packet with DT 0x%h at %0t", idi_dt, $time);
			errors++;
		end else begin
			dt       = exp_dt_q.pop_front();
			wc       = exp_wc_q.pop_front();
			cur_line = exp_line_q.pop_front();
			check_short(dt, wc);
			check_channel(vpg_vc, vpg_vcx);
			if (dt > 6'd3)
				exp_beats = (wc + 7) / 8;
		end
	endtask

	task automatic take_beat();
		logic [63:0] data;
		logic [2:0]  be;
		if (beat_i >= exp_beats) begin
			$display("Data beat at %0t outside a long packet", $time);
			errors++;
			return;
		end
		if (idi_header_en !== 1'b1) begin
			$display("MISMATCH at %0t: idi_header_en low during beat %0d", $time, beat_i);
			errors++;
		end
		for (int k = 0; k < 8; k++) begin
			if (vpg_pattern == pat_solid)
				data[8*k +: 8] = 8'(cur_line);
			else
				data[8*k +: 8] = 8'(cur_line + 8 * beat_i + k);
		end
		be = 3'd7;
		if (beat_i == exp_beats - 1 && vpg_pkt_size[2:0] != 3'd0)
			be = vpg_pkt_size[2:0] - 3'd1;	// Partial last beat
		check_long_beat(data, be, vpg_dt);
		check_channel(vpg_vc, vpg_vcx);
		beat_i++;
	endtask

	// Outputs settle well before the falling edge
	always @(negedge ppi_clk) begin
		if (mon_on) begin
			if (idi_header_en && !idi_data_en)
				take_header();
			else if (idi_data_en)
				take_beat();
			if (!idi_data_en)
				check_idle_data(idi_data);
		end
	end

	task automatic build_expected(input int frames);
		logic [15:0] fnum;
		logic [15:0] lnum;
		for (int f = 0; f < frames; f++) begin
			fnum = vpg_frame_num_mode ? 16'(f % vpg_max_frame_num + 1) : 16'd0;
			exp_dt_q.push_back(dt_fs);
			exp_wc_q.push_back(fnum);
			exp_line_q.push_back(0);
			for (int l = 0; l < vpg_vactive_lines; l++) begin
				lnum = vpg_line_num_mode ? 16'(vpg_start_line_num + vpg_step_line_num * l) : 16'd0;
				if (vpg_hsync_packet_en) begin
					exp_dt_q.push_back(dt_ls);
					exp_wc_q.push_back(lnum);
					exp_line_q.push_back(l);
				end
				exp_dt_q.push_back(vpg_dt);
				exp_wc_q.push_back(vpg_pkt_size);
				exp_line_q.push_back(l);
				if (vpg_hsync_packet_en) begin
					exp_dt_q.push_back(dt_le);
					exp_wc_q.push_back(lnum);
					exp_line_q.push_back(l);
				end
			end
			exp_dt_q.push_back(dt_fe);
			exp_wc_q.push_back(fnum);
			exp_line_q.push_back(0);
		end
	endtask

	task automatic run_test(input int t);
		int b;
		int err0;
		b    = t * NF;
		err0 = errors;
		@(posedge ppi_clk);
		ppi_clkrstz         <= 1'b0;
		vpg_vsa_lines       <= 10'(cfg_mem[b]);
		vpg_vbp_lines       <= 10'(cfg_mem[b+1]);
		vpg_vactive_lines   <= 10'(cfg_mem[b+2]);
		vpg_vfp_lines       <= 10'(cfg_mem[b+3]);
		vpg_hsa_time        <= 12'(cfg_mem[b+4]);
		vpg_hbp_time        <= 12'(cfg_mem[b+5]);
		vpg_hline_time      <= 12'(cfg_mem[b+6]);
		vpg_pkt_size        <= cfg_mem[b+7];
		vpg_dt              <= vpg_dt_e'(cfg_mem[b+8][5:0]);
		vpg_vc              <= cfg_mem[b+9][1:0];
		vpg_vcx             <= cfg_mem[b+10][1:0];
		vpg_pattern         <= vpg_pattern_e'(cfg_mem[b+11][0]);
		vpg_hsync_packet_en <= cfg_mem[b+12][0];
		vpg_frame_num_mode  <= cfg_mem[b+13][0];
		vpg_max_frame_num   <= cfg_mem[b+14];
		vpg_line_num_mode   <= cfg_mem[b+15][0];
		vpg_start_line_num  <= cfg_mem[b+16];
		vpg_step_line_num   <= cfg_mem[b+17];
		repeat (10) @(posedge ppi_clk);
		ppi_clkrstz <= 1'b1;
		exp_dt_q.delete();
		exp_wc_q.delete();
		exp_line_q.delete();
		build_expected(cfg_mem[b+18]);
		{got_short, got_long, fs_seen, fe_seen, exp_beats, beat_i} = '0;
		mon_on = 1'b1;
		@(posedge ppi_clk);
		vpg_en <= 1'b1;
		while (fs_seen < cfg_mem[b+18])
			@(posedge ppi_clk);
		vpg_en <= 1'b0;	// Last frame runs to its end
		while (fe_seen < cfg_mem[b+18])
			@(posedge ppi_clk);
		repeat ((vpg_vfp_lines + 2) * vpg_hline_time) @(posedge ppi_clk);
		mon_on = 1'b0;
		if (exp_dt_q.size() != 0 || beat_i != exp_beats) begin
			$display("Test %0d: %0d packets never appeared", t, exp_dt_q.size());
			errors++;
		end
		check_count(cfg_mem[b+19], cfg_mem[b+20], got_short, got_long);
		if (errors == err0) begin
			tests_pass++;
			$display("Test %0d done: ok, %0d short %0d long", t, got_short, got_long);
		end else begin
			tests_fail++;
			$display("Test %0d done: %0d errors", t, errors - err0);
		end
	endtask

	// Random legal frame, totals from the packet rules
	task automatic draw_random(input int t);
		int b;
		b = t * NF;
		cfg_mem[b]    = 16'($urandom_range(3, 1));
		cfg_mem[b+1]  = 16'($urandom_range(2, 0));
		cfg_mem[b+2]  = 16'($urandom_range(5, 1));
		cfg_mem[b+3]  = 16'($urandom_range(2, 1));
		cfg_mem[b+4]  = 16'($urandom_range(8, 1));
		cfg_mem[b+5]  = 16'($urandom_range(8, 0));
		cfg_mem[b+7]  = 16'($urandom_range(80, 1));
		cfg_mem[b+6]  = cfg_mem[b+4] + cfg_mem[b+5] + (cfg_mem[b+7] + 7) / 8 + 3
			+ 16'($urandom_range(10, 0));
		cfg_mem[b+8]  = $urandom_range(1, 0) ? 16'h2a : 16'h24;
		cfg_mem[b+9]  = 16'($urandom_range(3, 0));
		cfg_mem[b+10] = 16'($urandom_range(3, 0));
		cfg_mem[b+11] = 16'($urandom_range(1, 0));
		cfg_mem[b+12] = 16'($urandom_range(1, 0));
		cfg_mem[b+13] = 16'($urandom_range(1, 0));
		cfg_mem[b+14] = 16'($urandom_range(3, 1));
		cfg_mem[b+15] = 16'($urandom_range(1, 0));
		cfg_mem[b+16] = 16'($urandom);
		cfg_mem[b+17] = 16'($urandom_range(15, 0));
		cfg_mem[b+18] = 16'($urandom_range(2, 1));
		cfg_mem[b+19] = cfg_mem[b+18] * (2 + (cfg_mem[b+12][0] ? 2 * cfg_mem[b+2] : 0));
		cfg_mem[b+20] = cfg_mem[b+18] * cfg_mem[b+2];
	endtask

	initial begin
		int b;
		{vpg_en, vpg_vsa_lines, vpg_vbp_lines, vpg_vactive_lines, vpg_vfp_lines} = '0;
		{vpg_hsa_time, vpg_hbp_time, vpg_hline_time, vpg_pkt_size} = '0;
		{vpg_vc, vpg_vcx, vpg_hsync_packet_en, vpg_frame_num_mode, vpg_line_num_mode} = '0;
		{vpg_max_frame_num, vpg_start_line_num, vpg_step_line_num} = '0;
		vpg_dt      = dt_raw8;
		vpg_pattern = pat_ramp;
		ppi_clkrstz = 1'b0;
		{errors, tests_pass, tests_fail, num_tests} = '0;
		cycles      = 0;
		cycle_limit = 0;
		mon_on      = 1'b0;
		void'($urandom(81305));
		for (int i = 0; i < MAX_TESTS * NF; i++)
			cfg_mem[i] = '0;
		$readmemh("verification/vpg_stimulus.txt", cfg_mem);
		while (num_tests < MAX_TESTS - 1 && cfg_mem[num_tests * NF] != 16'd0)
			num_tests++;	// vsa of zero ends the list
		draw_random(num_tests);
		cycle_limit = 1000;
		for (int t = 0; t <= num_tests; t++) begin
			b = t * NF;
			cycle_limit += cfg_mem[b+6] * (cfg_mem[b+18] * (cfg_mem[b] + cfg_mem[b+1]
				+ cfg_mem[b+2] + cfg_mem[b+3]) + cfg_mem[b+3] + 2) + 100;
		end
		for (int t = 0; t <= num_tests; t++)
			run_test(t);
		$display("Tests: %0d passed, %0d failed, %0d errors", tests_pass, tests_fail, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// File: src.f
common/csi2_vpg_pkg.sv
vpg/vpg_frame_timing.sv
vpg/vpg_packet_builder.sv
logic/vpg_idi.sv
logic/csi2_device_vpg_top.sv
verification/tb_csi2_device_vpg.sv

// File: Makefile
# Verilator flow for the CSI-2 device VPG

VERILATOR ?= verilator
FILELIST  ?= src.f
TB_TOP    ?= tb_csi2_device_vpg
RTL_TOP   ?= csi2_device_vpg_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Verification failed
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TB_TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/vpg_stimulus.txt
// vsa vbp vact vfp hsa hbp hline pkt_size dt vc vcx pattern hsync fmode fmax lmode lstart lstep
// frames exp_short exp_long, all hex, one test per line
0001 0001 0003 0001 0004 0004 0020 0018 002a 0001 0000 0000 0001 0001 0003 0001 0010 0002 0004 0020 000c
0002 0000 0002 0001 0003 0002 0018 000d 0024 0002 0001 0001 0000 0000 0002 0000 0005 0003 0002 0004 0004
0001 0002 0004 0002 0002 0006 0040 0045 002a 0003 0003 0000 0001 0001 0002 0001 fff0 0007 0003 001e 000c
0001 0000 0002 0001 0001 0001 0010 0007 0024 0000 0002 0001 0001 0001 0001 0001 0000 0001 0003 0012 0006
0001 0001 0012 0001 0002 0003 0030 0100 002a 0001 0001 0000 0000 0001 0005 0000 0000 0000 0001 0002 0012
0001 0000 0001 0001 0001 0000 000c 0008 002a 0000 0000 0000 0001 0001 0002 0001 0003 0000 0005 0014 0005
